/* kogge_mult.f */
rtl/mult_pkg.sv
rtl/flow_pkg.sv
rtl/credit_fifo.sv
rtl/pp_reduce.sv
rtl/prefix_adder.sv
rtl/kogge_mult.sv
test/tb_clock.sv
test/kogge_mult_assert.sv
test/kogge_mult_tb.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= kogge_mult_tb
FILELIST ?= kogge_mult.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/kogge_mult_tb.sv */
`default_nettype none

module kogge_mult_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // every item finishes well within 80 cycles even through the stall.
    localparam int NUM_ITEMS      = 5 + 200 + 12 + 6 + 20;
    localparam int TIMEOUT_CYCLES = 80 * NUM_ITEMS + 500;
    localparam int STALL_ITEMS    = 12;

    logic               clk;
    logic               rst_n      = 1'b0;
    logic               in_valid   = 1'b0;
    mult_pkg::operand_t in_data    = '0;
    logic               in_credit;
    logic               out_valid;
    mult_pkg::product_t out_data;
    logic               out_credit = 1'b0;

    logic        credit_enable = 1'b1;
    logic [31:0] exp_q [$];
    integer      seed;
    int          send_credits  = flow_pkg::OPQ_DEPTH;
    int          owed          = 0;
    int          results_seen  = 0;
    int          credit_pulses = 0;
    int          overspend     = 0;
    int          cycle_count   = 0;
    int          sent_count    = 0;
    int          stall_credits = 0;
    int          check_count   = 0;
    int          error_count   = 0;

    tb_clock clock_gen (.clk(clk));

    kogge_mult uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

    // ============================================================
    // checking, credit bookkeeping and timeout
    // ============================================================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s expected %h got %h", name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            results_seen <= results_seen + 1;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("a result came out when none was expected");
            end else begin
                check_value("out_data", exp_q.pop_front(), out_data);
            end
        end
    end

    // the sender's own view of the operand queue.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            send_credits <= flow_pkg::OPQ_DEPTH;
        end else begin
            send_credits <= send_credits + int'(in_credit) - int'(in_valid);
            if (in_valid && uut.opq.count == flow_pkg::OPQ_DEPTH) begin
                overspend <= overspend + 1;
            end
            if (in_credit) begin
                credit_pulses <= credit_pulses + 1;
            end
        end
    end

    // downstream takes every result and hands its credit back when enabled.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owed       <= 0;
            out_credit <= 1'b0;
        end else if (credit_enable && owed > 0) begin
            owed       <= owed + int'(out_valid) - 1;
            out_credit <= 1'b1;
        end else begin
            owed       <= owed + int'(out_valid);
            out_credit <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ============================================================
    // stimulus helpers
    // ============================================================
    function automatic int avail_credits();
        return send_credits + int'(in_credit) - int'(in_valid);
    endfunction

    task automatic drive_pair(input logic [15:0] a, input logic [15:0] b);
        in_valid  <= 1'b1;
        in_data.a <= a;
        in_data.b <= b;
        exp_q.push_back({16'h0, a} * {16'h0, b});
        sent_count++;
    endtask

    task automatic send_pair(input logic [15:0] a, input logic [15:0] b);
        @(posedge clk);
        while (avail_credits() == 0) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        drive_pair(a, b);
    endtask

    task automatic send_random_pair();
        logic [31:0] r;
        r = $random(seed);
        send_pair(r[15:0], r[31:16]);
    endtask

    task automatic end_burst();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_results(input int target);
        while (results_seen < target) begin
            @(posedge clk);
        end
    endtask

    task automatic report(input int num, input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, error_count - errs_before);
        end
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic test_corners();
        int base;
        int errs;
        base = results_seen;
        errs = error_count;
        send_pair(16'h0000, 16'hffff);
        send_pair(16'h0001, 16'hffff);
        send_pair(16'hffff, 16'hffff);
        send_pair(16'h8000, 16'h8000);
        send_pair(16'haaaa, 16'h5555);
        end_burst();
        wait_results(base + 5);
        report(1, "corner operands", errs);
    endtask

    task automatic test_random_stream();
        int base;
        int errs;
        base = results_seen;
        errs = error_count;
        for (int i = 0; i < 200; i++) begin
            send_random_pair();
        end
        end_burst();
        wait_results(base + 200);
        report(2, "random stream", errs);
    endtask

    task automatic test_backpressure();
        int base;
        int errs;
        int sent;
        logic [31:0] r;
        base = results_seen;
        errs = error_count;
        sent = 0;
        credit_enable <= 1'b0;
        for (int c = 0; c < 40; c++) begin     // long enough to fill every stage.
            @(posedge clk);
            if (sent < STALL_ITEMS && avail_credits() > 0) begin
                r = $random(seed);
                drive_pair(r[15:0], r[31:16]);
                sent++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        stall_credits = avail_credits();
        check_value("results during stall", flow_pkg::RES_CREDITS, results_seen - base);
        repeat (20) @(posedge clk);
        check_value("results during stall", flow_pkg::RES_CREDITS, results_seen - base);
        credit_enable <= 1'b1;
        for (int i = sent; i < STALL_ITEMS; i++) begin
            send_random_pair();
        end
        end_burst();
        wait_results(base + STALL_ITEMS);
        report(3, "back-pressure", errs);
    endtask

    task automatic test_credit_totals();
        int errs;
        errs = error_count;
        repeat (4) @(posedge clk);
        if (stall_credits != 0) begin
            error_count++;
            $display("the sender still held credits during the stall");
        end
        if (overspend != 0) begin
            error_count++;
            $display("in_valid was raised while the operand queue was full");
        end
        check_value("in_credit pulses", sent_count, credit_pulses);
        report(4, "credit totals", errs);
    endtask

    task automatic test_mid_reset();
        int base;
        int errs;
        errs = error_count;
        for (int i = 0; i < 6; i++) begin
            send_random_pair();
        end
        @(posedge clk);
        in_valid <= 1'b0;
        rst_n    <= 1'b0;
        @(posedge clk);
        exp_q.delete();     // whatever was in flight is lost.
        repeat (5) begin
            @(posedge clk);
            check_value("out_valid", 32'h0, {31'h0, out_valid});
            check_value("in_credit", 32'h0, {31'h0, in_credit});
        end
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("merge credit_cnt", flow_pkg::RES_CREDITS, 32'(uut.merge.credit_cnt));
        check_value("opq free slots", flow_pkg::OPQ_DEPTH,
                    flow_pkg::OPQ_DEPTH - int'(uut.opq.count));
        base = results_seen;
        for (int i = 0; i < 20; i++) begin
            send_random_pair();
        end
        end_burst();
        wait_results(base + 20);
        report(5, "reset mid-stream", errs);
    endtask

    initial begin
        seed = 32'hd7e24b81;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_corners();
        test_random_stream();
        test_backpressure();
        test_credit_totals();
        test_mid_reset();
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected results never came out", exp_q.size());
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/kogge_mult_assert.sv */
`default_nettype none

module kogge_mult_assert (
    input logic                clk,
    input logic                rst_n,
    input logic                out_valid,
    input mult_pkg::product_t  out_data,
    input flow_pkg::credit_t   merge_credit,
    input logic                row_push,
    input flow_pkg::credit_t   reduce_credit
);
    timeunit 1ns;
    timeprecision 1ps;

    // a valid result carries no unknown bits.
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(out_data))
        else $error("out_data has unknown bits while out_valid is high");

    // the downstream pool never exceeds what the consumer was given.
    assert property (@(posedge clk) disable iff (!rst_n)
        merge_credit <= flow_pkg::credit_t'(flow_pkg::RES_CREDITS))
        else $error("merge credit counter above its initial count");

    assert property (@(posedge clk) disable iff (!rst_n)
        row_push |-> (reduce_credit != '0))
        else $error("row push while reduce holds no credit");

endmodule

bind kogge_mult kogge_mult_assert flow_checks (
    .clk           (clk),
    .rst_n         (rst_n),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .merge_credit  (merge.credit_cnt),
    .row_push      (row_push),
    .reduce_credit (reduce.credit_cnt)
);

`default_nettype wire

/* test/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD = 100;

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* rtl/kogge_mult.sv */
`default_nettype none

module kogge_mult (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               in_valid,
    input  mult_pkg::operand_t in_data,
    output logic               in_credit,

    output logic               out_valid,
    output mult_pkg::product_t out_data,
    input  logic               out_credit
);

    logic                op_avail;
    logic                op_pop;
    mult_pkg::operand_t  op_data;

    logic                row_push;
    mult_pkg::csa_rows_t rows;
    logic                row_credit;
    logic                row_avail;
    logic                row_pop;
    mult_pkg::csa_rows_t row_data;

    // ==========================================================
    // operand queue, reduction, row queue, final adder
    // ==========================================================
    credit_fifo #(
        .payload_t (mult_pkg::operand_t),
        .DEPTH     (flow_pkg::OPQ_DEPTH)
    ) opq (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (in_data),
        .avail     (op_avail),
        .pop       (op_pop),
        .pop_data  (op_data),
        .credit    (in_credit)      // credits go straight back to the sender.
    );

    pp_reduce reduce (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_avail   (op_avail),
        .op_data    (op_data),
        .op_pop     (op_pop),
        .row_push   (row_push),
        .rows       (rows),
        .row_credit (row_credit)
    );

    credit_fifo #(
        .payload_t (mult_pkg::csa_rows_t),
        .DEPTH     (flow_pkg::ROWQ_DEPTH)
    ) rowq (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (row_push),
        .push_data (rows),
        .avail     (row_avail),
        .pop       (row_pop),
        .pop_data  (row_data),
        .credit    (row_credit)
    );

    prefix_adder merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_avail  (row_avail),
        .row_data   (row_data),
        .row_pop    (row_pop),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

endmodule

`default_nettype wire

/* rtl/prefix_adder.sv */
`default_nettype none

module prefix_adder (
    input  logic                clk,
    input  logic                rst_n,

    // read side of the row queue.
    input  logic                row_avail,
    input  mult_pkg::csa_rows_t row_data,
    output logic                row_pop,

    // result port toward the consumer.
    output logic                out_valid,
    output mult_pkg::product_t  out_data,
    input  logic                out_credit
);

    // gen[k] and prop[k] hold the group terms after k prefix levels.
    logic [mult_pkg::PRODUCT_W-1:0] gen  [mult_pkg::PREFIX_LEVELS+1];
    logic [mult_pkg::PRODUCT_W-1:0] prop [mult_pkg::PREFIX_LEVELS+1];

    mult_pkg::product_t sum;
    flow_pkg::credit_t  credit_cnt;

    // ==========================================================
    // Kogge-Stone network
    // ==========================================================
    assign gen[0]  = row_data.sum_row & row_data.carry_row;
    assign prop[0] = row_data.sum_row ^ row_data.carry_row;

    for (genvar k = 0; k < mult_pkg::PREFIX_LEVELS; k++) begin : g_level
        for (genvar i = 0; i < mult_pkg::PRODUCT_W; i++) begin : g_bit
            if (i >= 2 * (1 << k)) begin : g_black
                // span still open at the bottom, keep both terms.
                assign gen[k+1][i]  = gen[k][i] | (prop[k][i] & gen[k][i-(1<<k)]);
                assign prop[k+1][i] = prop[k][i] & prop[k][i-(1<<k)];
            end else if (i >= (1 << k)) begin : g_gray
                assign gen[k+1][i]  = gen[k][i] | (prop[k][i] & gen[k][i-(1<<k)]);
                assign prop[k+1][i] = prop[k][i];   // no longer read above this level.
            end else begin : g_pass
                assign gen[k+1][i]  = gen[k][i];
                assign prop[k+1][i] = prop[k][i];
            end
        end
    end

    // gen at bit i-1 is the carry into bit i; there is no carry in.
    assign sum = prop[0] ^ {gen[mult_pkg::PREFIX_LEVELS][mult_pkg::PRODUCT_W-2:0], 1'b0};

    // ==========================================================
    // downstream credits and output register
    // ==========================================================
    // out_valid spends the credit that the pop a cycle earlier reserved.
    assign row_pop = row_avail && (credit_cnt > flow_pkg::credit_t'(out_valid));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= flow_pkg::credit_t'(flow_pkg::RES_CREDITS);
            out_valid  <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt + flow_pkg::credit_t'(out_credit)
                                     - flow_pkg::credit_t'(out_valid);
            out_valid  <= row_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (row_pop) begin
            out_data <= sum;
        end
    end

endmodule

`default_nettype wire

/* rtl/pp_reduce.sv */
`default_nettype none

module pp_reduce (
    input  logic                clk,
    input  logic                rst_n,

    // read side of the operand queue.
    input  logic                op_avail,
    input  mult_pkg::operand_t  op_data,
    output logic                op_pop,

    // write side of the row queue.
    output logic                row_push,
    output mult_pkg::csa_rows_t rows,
    input  logic                row_credit
);

    logic [mult_pkg::PRODUCT_W-1:0] b_ext;
    logic [mult_pkg::PRODUCT_W-1:0] pp [mult_pkg::NUM_PP];
    logic [mult_pkg::PRODUCT_W-1:0] sum_row;
    logic [mult_pkg::PRODUCT_W-1:0] carry_row;

    flow_pkg::credit_t credit_cnt;

    // ==========================================================
    // partial products
    // ==========================================================
    assign b_ext = {{(mult_pkg::PRODUCT_W - mult_pkg::OPERAND_W){1'b0}}, op_data.b};

    // bit i of a selects b, shifted up to weight i.
    for (genvar i = 0; i < mult_pkg::NUM_PP; i++) begin : g_pp
        assign pp[i] = op_data.a[i] ? (b_ext << i) : '0;
    end

    // ==========================================================
    // carry-save reduction
    // ==========================================================
    // Each layer groups the rows in threes and replaces every group with a
    // sum row and a shifted carry row. Leftover rows pass to the next layer.
    // Sixteen rows need six layers: 16, 11, 8, 6, 4, 3, 2.
    always_comb begin : csa_tree
        logic [mult_pkg::PRODUCT_W-1:0] r [mult_pkg::NUM_PP];
        logic [mult_pkg::PRODUCT_W-1:0] x;
        logic [mult_pkg::PRODUCT_W-1:0] y;
        logic [mult_pkg::PRODUCT_W-1:0] z;
        int n;
        int q;

        for (int i = 0; i < mult_pkg::NUM_PP; i++) begin
            r[i] = pp[i];
        end
        x = '0;
        y = '0;
        z = '0;
        n = mult_pkg::NUM_PP;

        for (int lv = 0; lv < mult_pkg::NUM_PP; lv++) begin
            if (n > 2) begin
                q = n / 3;
                for (int g = 0; g < mult_pkg::NUM_PP / 3; g++) begin
                    if (g < q) begin
                        x = r[3*g];
                        y = r[3*g+1];
                        z = r[3*g+2];
                        r[2*g]   = x ^ y ^ z;                           // full-adder sum.
                        r[2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;  // carry, one up.
                    end
                end
                for (int j = 0; j < 2; j++) begin
                    if (j < n % 3) begin
                        r[2*q+j] = r[3*q+j];
                    end
                end
                n = 2 * q + n % 3;
            end
        end

        sum_row   = r[0];
        carry_row = r[1];
    end

    // ==========================================================
    // flow control and output register
    // ==========================================================
    // A credit is reserved by the pop and spent by the push one cycle later,
    // so a push that is still in the register counts against the pool.
    assign op_pop = op_avail && (credit_cnt > flow_pkg::credit_t'(row_push));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= flow_pkg::credit_t'(flow_pkg::ROWQ_DEPTH);
            row_push   <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt + flow_pkg::credit_t'(row_credit)
                                     - flow_pkg::credit_t'(row_push);
            row_push   <= op_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (op_pop) begin
            rows.sum_row   <= sum_row;
            rows.carry_row <= carry_row;
        end
    end

endmodule

`default_nettype wire

/* rtl/credit_fifo.sv */
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     push,
    input  payload_t push_data,

    output logic     avail,
    input  logic     pop,
    output payload_t pop_data,

    output logic     credit     // one pulse per pop, a cycle later.
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // ==========================================================
    // storage
    // ==========================================================
    // the writer holds a credit for every push, so there is always room.
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];
    assign avail    = (count != '0);

    // ==========================================================
    // pointers, occupancy and credit return
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + CNT_W'(push) - CNT_W'(pop);
            credit <= pop;  // the freed slot goes back to the writer.
        end
    end

endmodule

`default_nettype wire

/* rtl/flow_pkg.sv */
`default_nettype none

package flow_pkg;

    // ==========================================================
    // queue depths and initial credit counts
    // ==========================================================

    // the upstream sender starts with one credit per operand slot.
    localparam int OPQ_DEPTH = 4;

    // pp_reduce starts with one credit per row slot.
    localparam int ROWQ_DEPTH = 2;

    // results the consumer may emit before downstream returns any.
    localparam int RES_CREDITS = 2;

    // ==========================================================
    // credit counters
    // ==========================================================
    localparam int MAX_CREDITS = (OPQ_DEPTH > ROWQ_DEPTH) ?
        ((OPQ_DEPTH > RES_CREDITS) ? OPQ_DEPTH : RES_CREDITS) :
        ((ROWQ_DEPTH > RES_CREDITS) ? ROWQ_DEPTH : RES_CREDITS);

    localparam int CREDIT_W = $clog2(MAX_CREDITS + 1);

    typedef logic [CREDIT_W-1:0] credit_t;  // holds 0 up to MAX_CREDITS.

endpackage

`default_nettype wire

/* rtl/mult_pkg.sv */
`default_nettype none

package mult_pkg;

    // ==========================================================
    // arithmetic widths
    // ==========================================================
    localparam int OPERAND_W = 16;
    localparam int PRODUCT_W = 2 * OPERAND_W;
    localparam int NUM_PP    = OPERAND_W;       // one partial product per bit of a.

    // log2 of the product width sets the depth of the prefix network.
    localparam int PREFIX_LEVELS = $clog2(PRODUCT_W);

    // ==========================================================
    // payload types
    // ==========================================================
    typedef struct packed {
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
    } operand_t;

    // redundant form of the product, the true value is sum_row + carry_row.
    typedef struct packed {
        logic [PRODUCT_W-1:0] sum_row;
        logic [PRODUCT_W-1:0] carry_row;
    } csa_rows_t;

    typedef logic [PRODUCT_W-1:0] product_t;

endpackage

`default_nettype wire
